/* hdl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    ////////////////////////////////////////
    // RAM geometry
    ////////////////////////////////////////

    // 12 KiB of 32-bit words
    localparam int mem_words = 3072;

    // Word index width, byte address bits [13:2]
    localparam int mem_addr_bits = 12;

    // First byte address past the RAM
    localparam logic [31:0] mem_limit = 32'h0000_3000;

    ////////////////////////////////////////
    // Access size
    ////////////////////////////////////////

    // Same encoding as the pipeline's width field
    typedef enum logic [1:0] {
        size_word = 2'd0,
        size_half = 2'd1,
        size_byte = 2'd2
    } access_size_t;

endpackage

`default_nettype wire

/* hdl/axi_pkg.sv */
`default_nettype none

package axi_pkg;

    // Bus widths
    localparam int axil_data_bits = 32;
    localparam int axil_addr_bits = 32;
    localparam int axil_strb_bits = axil_data_bits / 8;

    // BRESP / RRESP codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

/* hdl/axil_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface axil_if;

    // Write address channel
    logic                                awvalid;
    logic                                awready;
    logic [axi_pkg::axil_addr_bits-1:0]  awaddr;

    // Write data channel
    logic                                wvalid;
    logic                                wready;
    logic [axi_pkg::axil_data_bits-1:0]  wdata;
    logic [axi_pkg::axil_strb_bits-1:0]  wstrb;

    // Write response channel
    logic                                bvalid;
    logic                                bready;
    logic [1:0]                          bresp;

    // Read address channel
    logic                                arvalid;
    logic                                arready;
    logic [axi_pkg::axil_addr_bits-1:0]  araddr;

    // Read data channel
    logic                                rvalid;
    logic                                rready;
    logic [axi_pkg::axil_data_bits-1:0]  rdata;
    logic [1:0]                          rresp;

    modport master (
        output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

    modport slave (
        input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

endinterface

`default_nettype wire

/* hdl/mem_port.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_port (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_write,
    input  logic [31:0]           req_addr,
    input  mem_pkg::access_size_t req_size,
    input  logic                  req_signed,
    input  logic [31:0]           req_wdata,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output logic [31:0]           resp_rdata,
    output logic                  resp_err,
    axil_if.master                bus
);

    typedef enum logic [1:0] {
        st_idle,
        st_bus,
        st_resp
    } state_t;

    state_t                              state;
    logic                                aw_pend;
    logic                                w_pend;
    logic                                ar_pend;
    logic                                is_write;
    logic [1:0]                          addr_lo;
    mem_pkg::access_size_t               size_q;
    logic                                signed_q;
    logic [axi_pkg::axil_addr_bits-1:0]  addr_q;
    logic [axi_pkg::axil_data_bits-1:0]  wdata_q;
    logic [axi_pkg::axil_strb_bits-1:0]  strb_q;
    logic [axi_pkg::axil_data_bits-1:0]  lane_wdata;
    logic [axi_pkg::axil_strb_bits-1:0]  lane_strb;
    logic                                accept;
    logic                                misaligned;
    logic                                b_done;
    logic                                r_done;

    // Pick the lane of a loaded word and extend it
    function automatic logic [31:0] load_extend(
        input logic [31:0]           word,
        input logic [1:0]            lo,
        input mem_pkg::access_size_t size,
        input logic                  sgn
    );
        logic [15:0] half_v;
        logic [7:0]  byte_v;
        half_v = lo[1] ? word[31:16] : word[15:0];
        byte_v = word[{lo, 3'b000} +: 8];
        case (size)
            mem_pkg::size_half: return {{16{sgn & half_v[15]}}, half_v};
            mem_pkg::size_byte: return {{24{sgn & byte_v[7]}}, byte_v};
            default:            return word;
        endcase
    endfunction

    assign accept     = req_valid && req_ready;
    assign misaligned = (req_size == mem_pkg::size_half) && req_addr[0];
    assign b_done     = bus.bvalid && bus.bready;
    assign r_done     = bus.rvalid && bus.rready;

    assign req_ready  = (state == st_idle);
    assign resp_valid = (state == st_resp);

    ////////////////////////////////////////
    // Store lane placement
    ////////////////////////////////////////

    always_comb begin
        lane_wdata = req_wdata;
        lane_strb  = 4'b1111;
        case (req_size)
            mem_pkg::size_half: begin
                lane_wdata = {2{req_wdata[15:0]}};
                lane_strb  = req_addr[1] ? 4'b1100 : 4'b0011;
            end
            mem_pkg::size_byte: begin
                lane_wdata = {4{req_wdata[7:0]}};
                lane_strb  = 4'b0001 << req_addr[1:0];
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // Request FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
            ar_pend <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept && misaligned) begin
                        // Answered without touching the bus
                        state <= st_resp;
                    end else if (accept) begin
                        state   <= st_bus;
                        aw_pend <= req_write;
                        w_pend  <= req_write;
                        ar_pend <= !req_write;
                    end
                end
                st_bus: begin
                    if (bus.awready) aw_pend <= 1'b0;
                    if (bus.wready)  w_pend  <= 1'b0;
                    if (bus.arready) ar_pend <= 1'b0;
                    if (b_done || r_done) state <= st_resp;
                end
                st_resp: begin
                    if (resp_ready) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            is_write <= req_write;
            addr_lo  <= req_addr[1:0];
            size_q   <= req_size;
            signed_q <= req_signed;
            addr_q   <= {req_addr[31:2], 2'b00};
            wdata_q  <= lane_wdata;
            strb_q   <= lane_strb;
        end
        if (accept && misaligned) begin
            resp_rdata <= '0;
            resp_err   <= 1'b1;
        end else if (b_done) begin
            resp_rdata <= '0;
            resp_err   <= (bus.bresp == axi_pkg::resp_slverr);
        end else if (r_done) begin
            resp_rdata <= load_extend(bus.rdata, addr_lo, size_q, signed_q);
            resp_err   <= (bus.rresp == axi_pkg::resp_slverr);
        end
    end

    // Bus side
    assign bus.awvalid = aw_pend;
    assign bus.awaddr  = addr_q;
    assign bus.wvalid  = w_pend;
    assign bus.wdata   = wdata_q;
    assign bus.wstrb   = strb_q;
    assign bus.arvalid = ar_pend;
    assign bus.araddr  = addr_q;
    assign bus.bready  = (state == st_bus) && is_write;
    assign bus.rready  = (state == st_bus) && !is_write;

endmodule

`default_nettype wire

/* hdl/axil_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_arbiter (
    input  logic   clk,
    input  logic   reset,
    axil_if.slave  m0,
    axil_if.slave  m1,
    axil_if.master s
);

    logic busy;
    logic grant;
    logic last;
    logic req0;
    logic req1;
    logic pick;
    logic sel;
    logic done;

    assign req0 = m0.awvalid || m0.arvalid;
    assign req1 = m1.awvalid || m1.arvalid;

    // Tie goes to whoever was not served last
    always_comb begin
        if (req0 && req1) begin
            pick = !last;
        end else begin
            pick = req1;
        end
    end

    // Idle grants in the same cycle as the request
    assign sel  = busy ? grant : pick;
    assign done = (s.bvalid && s.bready) || (s.rvalid && s.rready);

    ////////////////////////////////////////
    // Grant state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            grant <= 1'b0;
            last  <= 1'b1;
        end else if (!busy) begin
            if (req0 || req1) begin
                busy  <= 1'b1;
                grant <= pick;
            end
        end else if (done) begin
            busy <= 1'b0;
            last <= grant;
        end
    end

    ////////////////////////////////////////
    // Master to slave
    ////////////////////////////////////////

    assign s.awvalid = sel ? m1.awvalid : m0.awvalid;
    assign s.awaddr  = sel ? m1.awaddr  : m0.awaddr;
    assign s.wvalid  = sel ? m1.wvalid  : m0.wvalid;
    assign s.wdata   = sel ? m1.wdata   : m0.wdata;
    assign s.wstrb   = sel ? m1.wstrb   : m0.wstrb;
    assign s.bready  = sel ? m1.bready  : m0.bready;
    assign s.arvalid = sel ? m1.arvalid : m0.arvalid;
    assign s.araddr  = sel ? m1.araddr  : m0.araddr;
    assign s.rready  = sel ? m1.rready  : m0.rready;

    ////////////////////////////////////////
    // Slave to masters
    ////////////////////////////////////////

    // The waiting master sees no ready and no response
    assign m0.awready = !sel && s.awready;
    assign m0.wready  = !sel && s.wready;
    assign m0.arready = !sel && s.arready;
    assign m0.bvalid  = !sel && s.bvalid;
    assign m0.rvalid  = !sel && s.rvalid;

    assign m1.awready = sel && s.awready;
    assign m1.wready  = sel && s.wready;
    assign m1.arready = sel && s.arready;
    assign m1.bvalid  = sel && s.bvalid;
    assign m1.rvalid  = sel && s.rvalid;

    // Payloads are shared, valid qualifies them
    assign m0.bresp = s.bresp;
    assign m0.rdata = s.rdata;
    assign m0.rresp = s.rresp;
    assign m1.bresp = s.bresp;
    assign m1.rdata = s.rdata;
    assign m1.rresp = s.rresp;

endmodule

`default_nettype wire

/* hdl/dmem_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_sram (
    input  logic  clk,
    input  logic  reset,
    axil_if.slave bus
);

    logic [axi_pkg::axil_data_bits-1:0] ram [mem_pkg::mem_words];

    logic                               idle;
    logic                               wr_go;
    logic                               rd_go;
    logic                               wr_ok;
    logic                               rd_ok;
    logic [mem_pkg::mem_addr_bits-1:0]  widx;
    logic [mem_pkg::mem_addr_bits-1:0]  ridx;

    // Contents start cleared at time zero
    initial begin
        for (int i = 0; i < mem_pkg::mem_words; i++) begin
            ram[i] = '0;
        end
    end

    // No new request while a response is held
    assign idle  = !bus.bvalid && !bus.rvalid;
    assign wr_go = idle && bus.awvalid && bus.wvalid;
    assign rd_go = idle && bus.arvalid && !wr_go;

    assign bus.awready = wr_go;
    assign bus.wready  = wr_go;
    assign bus.arready = rd_go;

    assign wr_ok = bus.awaddr < mem_pkg::mem_limit;
    assign rd_ok = bus.araddr < mem_pkg::mem_limit;
    assign widx  = bus.awaddr[mem_pkg::mem_addr_bits+1:2];
    assign ridx  = bus.araddr[mem_pkg::mem_addr_bits+1:2];

    ////////////////////////////////////////
    // Array and response payload
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_go && wr_ok) begin
            for (int b = 0; b < axi_pkg::axil_strb_bits; b++) begin
                if (bus.wstrb[b]) begin
                    ram[widx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
        if (wr_go) begin
            bus.bresp <= wr_ok ? axi_pkg::resp_okay : axi_pkg::resp_slverr;
        end
        if (rd_go) begin
            bus.rdata <= rd_ok ? ram[ridx] : '0;
            bus.rresp <= rd_ok ? axi_pkg::resp_okay : axi_pkg::resp_slverr;
        end
    end

    // Response valids
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.bvalid <= 1'b0;
            bus.rvalid <= 1'b0;
        end else begin
            if (wr_go) begin
                bus.bvalid <= 1'b1;
            end else if (bus.bready) begin
                bus.bvalid <= 1'b0;
            end
            if (rd_go) begin
                bus.rvalid <= 1'b1;
            end else if (bus.rready) begin
                bus.rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/mips_dmem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_dmem_top (
    input  logic                               clk,
    input  logic                               reset,
    // CPU memory stage
    input  logic                               req_valid,
    output logic                               req_ready,
    input  logic                               req_write,
    input  logic [31:0]                        req_addr,
    input  mem_pkg::access_size_t              req_size,
    input  logic                               req_signed,
    input  logic [31:0]                        req_wdata,
    output logic                               resp_valid,
    input  logic                               resp_ready,
    output logic [31:0]                        resp_rdata,
    output logic                               resp_err,
    // Debug and loader bus
    input  logic                               dbg_awvalid,
    output logic                               dbg_awready,
    input  logic [axi_pkg::axil_addr_bits-1:0] dbg_awaddr,
    input  logic                               dbg_wvalid,
    output logic                               dbg_wready,
    input  logic [axi_pkg::axil_data_bits-1:0] dbg_wdata,
    input  logic [axi_pkg::axil_strb_bits-1:0] dbg_wstrb,
    output logic                               dbg_bvalid,
    input  logic                               dbg_bready,
    output logic [1:0]                         dbg_bresp,
    input  logic                               dbg_arvalid,
    output logic                               dbg_arready,
    input  logic [axi_pkg::axil_addr_bits-1:0] dbg_araddr,
    output logic                               dbg_rvalid,
    input  logic                               dbg_rready,
    output logic [axi_pkg::axil_data_bits-1:0] dbg_rdata,
    output logic [1:0]                         dbg_rresp
);

    axil_if cpu_bus ();
    axil_if dbg_bus ();
    axil_if mem_bus ();

    // Debug pins onto the bus bundle
    assign dbg_bus.awvalid = dbg_awvalid;
    assign dbg_bus.awaddr  = dbg_awaddr;
    assign dbg_bus.wvalid  = dbg_wvalid;
    assign dbg_bus.wdata   = dbg_wdata;
    assign dbg_bus.wstrb   = dbg_wstrb;
    assign dbg_bus.bready  = dbg_bready;
    assign dbg_bus.arvalid = dbg_arvalid;
    assign dbg_bus.araddr  = dbg_araddr;
    assign dbg_bus.rready  = dbg_rready;

    assign dbg_awready = dbg_bus.awready;
    assign dbg_wready  = dbg_bus.wready;
    assign dbg_bvalid  = dbg_bus.bvalid;
    assign dbg_bresp   = dbg_bus.bresp;
    assign dbg_arready = dbg_bus.arready;
    assign dbg_rvalid  = dbg_bus.rvalid;
    assign dbg_rdata   = dbg_bus.rdata;
    assign dbg_rresp   = dbg_bus.rresp;

    mem_port port0 (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_size   (req_size),
        .req_signed (req_signed),
        .req_wdata  (req_wdata),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_rdata (resp_rdata),
        .resp_err   (resp_err),
        .bus        (cpu_bus)
    );

    // CPU is m0, debug is m1
    axil_arbiter arb0 (
        .clk   (clk),
        .reset (reset),
        .m0    (cpu_bus),
        .m1    (dbg_bus),
        .s     (mem_bus)
    );

    dmem_sram ram0 (
        .clk   (clk),
        .reset (reset),
        .bus   (mem_bus)
    );

endmodule

`default_nettype wire

/* verification/tb_mips_dmem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_dmem;

    localparam int n_word  = 40;
    localparam int n_sub   = 60;
    localparam int n_conc  = 40;
    localparam int n_cross = 30;
    localparam int n_err   = 20;
    localparam int win     = 32'h200;
    // Bus operations issued over the whole run
    localparam int n_ops   = n_word + 2 * n_sub + 4 * n_conc + 4 * n_cross + 5 * n_err + win / 4;
    localparam int watchdog_ns = n_ops * 40 * 20;

    logic clk, reset;
    logic req_valid, req_ready, req_write, req_signed;
    logic [31:0] req_addr, req_wdata, resp_rdata;
    mem_pkg::access_size_t req_size;
    logic resp_valid, resp_ready, resp_err;
    logic dbg_awvalid, dbg_awready, dbg_wvalid, dbg_wready;
    logic [31:0] dbg_awaddr, dbg_wdata, dbg_araddr, dbg_rdata;
    logic [3:0] dbg_wstrb;
    logic dbg_bvalid, dbg_bready, dbg_arvalid, dbg_arready, dbg_rvalid, dbg_rready;
    logic [1:0] dbg_bresp, dbg_rresp;
    integer seed;

    // Byte image of the RAM in little-endian lane order
    logic [7:0] model [0:mem_pkg::mem_limit-1];

    mips_dmem_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////
    // Checking and model
    ////////////////////////////////////////

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic logic coin();
        integer r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        return {model[a + 3], model[a + 2], model[a + 1], model[a]};
    endfunction

    function automatic logic [31:0] expect_load(input logic [31:0] addr,
                                                input mem_pkg::access_size_t size,
                                                input logic sgn);
        logic [15:0] h;
        logic [7:0]  b;
        case (size)
            mem_pkg::size_half: begin
                h = {model[addr + 1], model[addr]};
                return sgn ? {{16{h[15]}}, h} : {16'h0, h};
            end
            mem_pkg::size_byte: begin
                b = model[addr];
                return sgn ? {{24{b[7]}}, b} : {24'h0, b};
            end
            default: return model_word(addr);
        endcase
    endfunction

    task automatic model_store(input logic [31:0] addr, input mem_pkg::access_size_t size,
                               input logic [31:0] data);
        case (size)
            mem_pkg::size_half: begin
                model[addr]     = data[7:0];
                model[addr + 1] = data[15:8];
            end
            mem_pkg::size_byte: model[addr] = data[7:0];
            default: begin
                for (int i = 0; i < 4; i++) begin
                    model[{addr[31:2], 2'b00} + i] = data[8*i +: 8];
                end
            end
        endcase
    endtask

    ////////////////////////////////////////
    // CPU port
    ////////////////////////////////////////

    task automatic cpu_op(input logic w, input logic [31:0] addr,
                          input mem_pkg::access_size_t size, input logic sgn,
                          input logic [31:0] wdata);
        logic        bad;
        logic        held;
        logic        done;
        logic        err;
        logic [31:0] exp;
        logic [31:0] data;
        bad = (addr >= mem_pkg::mem_limit) || (size == mem_pkg::size_half && addr[0]);
        exp = (w || bad) ? 32'h0 : expect_load(addr, size, sgn);
        @(posedge clk);
        #1;
        req_valid  = 1'b1;
        req_write  = w;
        req_addr   = addr;
        req_size   = size;
        req_signed = sgn;
        req_wdata  = wdata;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        held = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            compare(req_ready, 1'b0, "req_ready while a response is pending");
            if (resp_valid) begin
                if (held) begin
                    compare(resp_rdata, data, "resp_rdata held under back-pressure");
                    compare(resp_err, err, "resp_err held under back-pressure");
                end
                data = resp_rdata;
                err  = resp_err;
                held = 1'b1;
                done = resp_ready;
            end
            @(posedge clk);
            #1;
            resp_ready = coin();
        end
        compare(err, bad, "CPU resp_err");
        compare(data, exp, "CPU response data");
        if (w && !bad) model_store(addr, size, wdata);
    endtask

    // Random sized access and a word load after each store
    task automatic cpu_random(input logic [31:0] base, input logic [31:0] mask);
        integer                r;
        logic [31:0]           addr;
        mem_pkg::access_size_t size;
        r    = $random(seed);
        addr = base + (($unsigned(r) >> 8) & mask);
        case (r[3:2])
            2'd0:    size = mem_pkg::size_word;
            2'd1:    size = mem_pkg::size_half;
            default: size = mem_pkg::size_byte;
        endcase
        if (size == mem_pkg::size_half) addr[0] = 1'b0;
        if (size == mem_pkg::size_word) addr[1:0] = 2'b00;
        cpu_op(r[0], addr, size, r[1], $random(seed));
        if (r[0]) cpu_op(1'b0, {addr[31:2], 2'b00}, mem_pkg::size_word, 1'b0, 32'h0);
    endtask

    ////////////////////////////////////////
    // Debug port
    ////////////////////////////////////////

    task automatic dbg_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic       bad;
        logic       held;
        logic       done;
        logic [1:0] resp;
        bad = addr >= mem_pkg::mem_limit;
        @(posedge clk);
        #1;
        dbg_awvalid = 1'b1;
        dbg_awaddr  = addr;
        dbg_wvalid  = 1'b1;
        dbg_wdata   = data;
        dbg_wstrb   = strb;
        @(negedge clk);
        while (!dbg_awready) @(negedge clk);
        compare(dbg_wready, 1'b1, "debug W accepted with AW");
        @(posedge clk);
        #1;
        dbg_awvalid = 1'b0;
        dbg_wvalid  = 1'b0;
        held = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (dbg_bvalid) begin
                if (held) compare(dbg_bresp, resp, "BRESP held under back-pressure");
                resp = dbg_bresp;
                held = 1'b1;
                done = dbg_bready;
            end
            @(posedge clk);
            #1;
            dbg_bready = coin();
        end
        compare(resp, bad ? axi_pkg::resp_slverr : axi_pkg::resp_okay, "debug BRESP");
        if (!bad) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) model[addr + i] = data[8*i +: 8];
            end
        end
    endtask

    task automatic dbg_read(input logic [31:0] addr);
        logic        bad;
        logic        held;
        logic        done;
        logic [1:0]  resp;
        logic [31:0] exp;
        logic [31:0] data;
        bad = addr >= mem_pkg::mem_limit;
        exp = bad ? 32'h0 : model_word(addr);
        @(posedge clk);
        #1;
        dbg_arvalid = 1'b1;
        dbg_araddr  = addr;
        @(negedge clk);
        while (!dbg_arready) @(negedge clk);
        @(posedge clk);
        #1;
        dbg_arvalid = 1'b0;
        held = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (dbg_rvalid) begin
                if (held) begin
                    compare(dbg_rdata, data, "RDATA held under back-pressure");
                    compare(dbg_rresp, resp, "RRESP held under back-pressure");
                end
                data = dbg_rdata;
                resp = dbg_rresp;
                held = 1'b1;
                done = dbg_rready;
            end
            @(posedge clk);
            #1;
            dbg_rready = coin();
        end
        compare(resp, bad ? axi_pkg::resp_slverr : axi_pkg::resp_okay, "debug RRESP");
        compare(data, exp, "debug read data");
    endtask

    task automatic dbg_random(input logic [31:0] base, input logic [31:0] mask);
        integer      r;
        logic [31:0] addr;
        r    = $random(seed);
        addr = base + ((($unsigned(r) >> 8) & mask) & ~32'h3);
        if (r[0]) dbg_write(addr, $random(seed), r[7:4]);
        else dbg_read(addr);
    endtask

    // Addresses past the RAM that partly alias the low window in the index bits
    function automatic logic [31:0] far_addr();
        integer r;
        r = $random(seed);
        case (r[1:0])
            2'd0:    return 32'h3000 + (r & 32'hffc);
            2'd1:    return 32'h4000 + (r & 32'h1fc);
            default: return {r[31:2], 2'b00} | 32'h8000_0000;
        endcase
    endfunction

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        integer      r;
        logic [31:0] addr;
        seed = 32'he17e;
        reset = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = 32'h0;
        req_size = mem_pkg::size_word;
        req_signed = 1'b0;
        req_wdata = 32'h0;
        resp_ready = 1'b0;
        dbg_awvalid = 1'b0;
        dbg_awaddr = 32'h0;
        dbg_wvalid = 1'b0;
        dbg_wdata = 32'h0;
        dbg_wstrb = 4'h0;
        dbg_bready = 1'b0;
        dbg_arvalid = 1'b0;
        dbg_araddr = 32'h0;
        dbg_rready = 1'b0;
        for (int i = 0; i < mem_pkg::mem_limit; i++) begin
            model[i] = 8'h00;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        compare(req_ready, 1'b1, "req_ready after reset");
        compare(resp_valid, 1'b0, "resp_valid after reset");
        compare(dbg_bvalid | dbg_rvalid, 1'b0, "debug response valid after reset");

        // Word stores and loads
        repeat (n_word) begin
            r = $random(seed);
            cpu_op(r[0], {23'h0, r[8:2], 2'b00}, mem_pkg::size_word, 1'b0, $random(seed));
        end

        // Half and byte lanes with zero and sign extension
        repeat (n_sub) cpu_random(32'h0, win - 1);

        // Both peers at once on separate halves of the window
        fork
            repeat (n_conc) cpu_random(32'h0, 32'hff);
            repeat (2 * n_conc) dbg_random(32'h100, 32'hff);
        join

        // Each peer reads what the other wrote
        repeat (n_cross) begin
            r = $random(seed);
            addr = {23'h0, r[8:2], 2'b00};
            dbg_write(addr, $random(seed), r[12:9]);
            cpu_op(1'b0, addr, mem_pkg::size_word, 1'b0, 32'h0);
            cpu_op(1'b1, addr + r[14:13], mem_pkg::size_byte, 1'b0, $random(seed));
            dbg_read(addr);
        end

        // Out of range and misaligned accesses
        repeat (n_err) begin
            r = $random(seed);
            cpu_op(r[0], far_addr(), mem_pkg::size_word, 1'b0, $random(seed));
            dbg_write(far_addr(), $random(seed), 4'hf);
            dbg_read(far_addr());
            addr = {23'h0, r[8:1], 1'b1};
            cpu_op(r[1], addr, mem_pkg::size_half, r[2], $random(seed));
            cpu_op(1'b0, {addr[31:2], 2'b00}, mem_pkg::size_word, 1'b0, 32'h0);
        end

        // Whole window against the model
        for (int a = 0; a < win; a += 4) begin
            dbg_read(a);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* mips_dmem.f */
hdl/mem_pkg.sv
hdl/axi_pkg.sv
hdl/axil_if.sv
hdl/mem_port.sv
hdl/axil_arbiter.sv
hdl/dmem_sram.sv
hdl/mips_dmem_top.sv
verification/tb_mips_dmem.sv
